//--- spiFlash_consts.svh
// constants for the SPI flash read pipeline
// sck divider, credit buffer depths and request length width
`ifndef SPIFLASH_CONSTS_SVH
`define SPIFLASH_CONSTS_SVH

// clk cycles per sck half-period
`define SPI_CLK_DIV 2

// receiver buffer depths, also the initial credit count of each sender
`define REQ_DEPTH 2     // sequencer request queue
`define ENG_DEPTH 2     // engine input buffer
`define RD_FIFO_DEPTH 4 // collector read fifo

// byte count field of a request
`define MAX_LEN_W 8

`endif

//--- spiFlashPkg.sv
// shared types of the flash read pipeline
// flash opcodes, sequencer and engine FSM states
// request, spi byte and read byte structs passed between stages
`include "spiFlash_consts.svh"

package spiFlashPkg;

	// supported commands, everything else is out of scope
	typedef enum logic [7:0] {
		OP_READ  = 8'h03, // read data, 24-bit address follows
		OP_JEDEC = 8'h9F  // manufacturer and device id
	} flashOp;

	typedef struct packed {
		flashOp op;
		logic [23:0] addr;           // unused for jedec
		logic [`MAX_LEN_W-1:0] len;  // data bytes wanted
	} flashReq;

	// one byte on the spi wire plus its tags
	typedef struct packed {
		logic [7:0] data;
		logic isData; // keep the received byte
		logic last;   // release csx after this byte
	} spiByte;

	typedef struct packed {
		logic [7:0] data;
		logic last; // final data byte of the request
	} rdByte;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_OPCODE,
		SEQ_ADDR,
		SEQ_DATA
	} seqState;

	typedef enum logic [1:0] {
		ENG_IDLE,
		ENG_SHIFT,
		ENG_HOLD // csx release half-period
	} engState;

endpackage

//--- flashCmdSequencer.sv
// command sequencer of the flash read pipeline
// request queue with credit return, FSM expanding a request into
// opcode, address and dummy bytes, credit counter toward the engine
`timescale 1ns/1ps
`include "spiFlash_consts.svh"

module flashCmdSequencer (
	input  logic clk,
	input  logic rst,
	input  logic reqValid,
	input  spiFlashPkg::flashReq req,
	output logic reqCredit,
	output logic txValid,
	output spiFlashPkg::spiByte tx,
	input  logic txCredit
);
	localparam int ptrW = (`REQ_DEPTH > 1) ? $clog2(`REQ_DEPTH) : 1;
	localparam int qCntW = $clog2(`REQ_DEPTH + 1);
	localparam int txCntW = $clog2(`ENG_DEPTH + 1);

	spiFlashPkg::flashReq qMem [`REQ_DEPTH]; // request queue storage
	logic [ptrW-1:0] qWrPtr;
	logic [ptrW-1:0] qRdPtr;
	logic [qCntW-1:0] qCount;
	logic qPop; // FSM takes the head request

	spiFlashPkg::seqState state;
	spiFlashPkg::flashReq cur;   // request being expanded
	logic [23:0] addrSh;         // address goes out msb byte first
	logic [1:0] addrIdx;         // address byte index 0..2
	logic [`MAX_LEN_W-1:0] remLen; // dummy bytes still owed
	logic [txCntW-1:0] txCnt;    // engine buffer slots we may fill
	logic send;
	spiFlashPkg::spiByte nextByte;

	assign qPop = (state == spiFlashPkg::SEQ_IDLE) && (qCount != '0);
	assign send = (state != spiFlashPkg::SEQ_IDLE) && (txCnt != '0); // one byte per cycle on credit

	always_ff @(posedge clk) begin
		if (reqValid)
			qMem[qWrPtr] <= req;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			qWrPtr <= '0;
			qRdPtr <= '0;
			qCount <= '0;
			txCnt <= txCntW'(`ENG_DEPTH); // engine buffer starts empty
		end else begin
			if (reqValid)
				qWrPtr <= (qWrPtr == ptrW'(`REQ_DEPTH - 1)) ? '0 : qWrPtr + 1'b1;
			if (qPop)
				qRdPtr <= (qRdPtr == ptrW'(`REQ_DEPTH - 1)) ? '0 : qRdPtr + 1'b1;
			qCount <= qCount + qCntW'(reqValid) - qCntW'(qPop);
			txCnt <= txCnt - txCntW'(send) + txCntW'(txCredit);
		end
	end

	// byte for the current state
	always_comb begin
		nextByte.data = 8'h00; // dummy byte, flash answers with data
		nextByte.isData = 1'b0;
		nextByte.last = 1'b0;
		case (state)
			spiFlashPkg::SEQ_OPCODE: begin
				nextByte.data = cur.op;
				nextByte.last = (cur.op != spiFlashPkg::OP_READ) && (cur.len == '0);
			end
			spiFlashPkg::SEQ_ADDR: begin
				nextByte.data = addrSh[23:16];
				nextByte.last = (addrIdx == 2'd2) && (cur.len == '0);
			end
			spiFlashPkg::SEQ_DATA: begin
				nextByte.isData = 1'b1;
				nextByte.last = (remLen == `MAX_LEN_W'(1));
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= spiFlashPkg::SEQ_IDLE;
			reqCredit <= 1'b0;
			txValid <= 1'b0;
		end else begin
			reqCredit <= qPop; // slot freed when the FSM takes it
			txValid <= send;
			case (state)
				spiFlashPkg::SEQ_IDLE:
					if (qPop)
						state <= spiFlashPkg::SEQ_OPCODE;
				spiFlashPkg::SEQ_OPCODE:
					if (send) begin
						if (cur.op == spiFlashPkg::OP_READ)
							state <= spiFlashPkg::SEQ_ADDR;
						else
							state <= nextByte.last ? spiFlashPkg::SEQ_IDLE : spiFlashPkg::SEQ_DATA;
					end
				spiFlashPkg::SEQ_ADDR:
					if (send && addrIdx == 2'd2)
						state <= nextByte.last ? spiFlashPkg::SEQ_IDLE : spiFlashPkg::SEQ_DATA;
				spiFlashPkg::SEQ_DATA:
					if (send && nextByte.last)
						state <= spiFlashPkg::SEQ_IDLE;
				default: state <= spiFlashPkg::SEQ_IDLE;
			endcase
		end
	end

	// request latch and byte payload
	always_ff @(posedge clk) begin
		if (qPop) begin
			cur <= qMem[qRdPtr];
			addrSh <= qMem[qRdPtr].addr;
			addrIdx <= 2'd0;
			remLen <= qMem[qRdPtr].len;
		end
		if (send) begin
			tx <= nextByte;
			if (state == spiFlashPkg::SEQ_ADDR) begin
				addrSh <= {addrSh[15:0], 8'h00};
				addrIdx <= addrIdx + 2'd1;
			end
			if (state == spiFlashPkg::SEQ_DATA)
				remLen <= remLen - 1'b1;
		end
	end

endmodule

//--- spiByteEngine.sv
// SPI byte engine, mode 0, msb first
// input buffer with credit return, sck divider, shift register,
// csx control across a transaction, credit counter toward the collector
`timescale 1ns/1ps
`include "spiFlash_consts.svh"

module spiByteEngine (
	input  logic clk,
	input  logic rst,
	input  logic txValid,
	input  spiFlashPkg::spiByte tx,
	output logic txCredit,
	output logic rxValid,
	output spiFlashPkg::spiByte rx,
	input  logic rxCredit,
	output logic sck,
	output logic csx,
	output logic sdo,
	input  logic sdi
);
	localparam int ptrW = (`ENG_DEPTH > 1) ? $clog2(`ENG_DEPTH) : 1;
	localparam int bufCntW = $clog2(`ENG_DEPTH + 1);
	localparam int rxCntW = $clog2(`RD_FIFO_DEPTH + 1);
	localparam int divW = $clog2(`SPI_CLK_DIV + 1);

	spiFlashPkg::spiByte bufMem [`ENG_DEPTH];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [bufCntW-1:0] bufCount;
	logic [rxCntW-1:0] rxCnt; // free collector slots

	spiFlashPkg::engState state;
	logic [7:0] shReg;        // tx bits leave at the top, rx bits enter at the bottom
	logic curIsData;
	logic curLast;
	logic [divW-1:0] divCnt;
	logic [3:0] bitCnt;       // rising edges seen in this byte
	logic halfTick;           // end of a sck half-period
	logic start;
	logic byteDone;           // eighth falling edge

	assign start = (state == spiFlashPkg::ENG_IDLE) && (bufCount != '0) && (rxCnt != '0);
	assign halfTick = (divCnt == divW'(`SPI_CLK_DIV - 1));
	assign byteDone = (state == spiFlashPkg::ENG_SHIFT) && halfTick && sck && (bitCnt == 4'd8);

	always_ff @(posedge clk) begin
		if (txValid)
			bufMem[wrPtr] <= tx;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			bufCount <= '0;
			rxCnt <= rxCntW'(`RD_FIFO_DEPTH);
		end else begin
			if (txValid)
				wrPtr <= (wrPtr == ptrW'(`ENG_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (start)
				rdPtr <= (rdPtr == ptrW'(`ENG_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			bufCount <= bufCount + bufCntW'(txValid) - bufCntW'(start);
			rxCnt <= rxCnt - rxCntW'(start) + rxCntW'(rxCredit); // reserve a slot per byte
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= spiFlashPkg::ENG_IDLE;
			sck <= 1'b0;
			csx <= 1'b1;
			sdo <= 1'b0;
			divCnt <= '0;
			bitCnt <= '0;
			txCredit <= 1'b0;
			rxValid <= 1'b0;
		end else begin
			txCredit <= start; // buffer slot frees as the byte starts
			rxValid <= byteDone;
			divCnt <= (state == spiFlashPkg::ENG_IDLE || halfTick) ? '0 : divCnt + 1'b1;
			case (state)
				spiFlashPkg::ENG_IDLE:
					if (start) begin
						state <= spiFlashPkg::ENG_SHIFT;
						csx <= 1'b0; // no-op inside a transaction
						sdo <= bufMem[rdPtr].data[7];
						bitCnt <= '0;
					end
				spiFlashPkg::ENG_SHIFT:
					if (halfTick) begin
						sck <= ~sck;
						if (!sck)
							bitCnt <= bitCnt + 4'd1; // rising edge, flash samples sdo
						else if (byteDone) begin
							sdo <= 1'b0;
							state <= curLast ? spiFlashPkg::ENG_HOLD : spiFlashPkg::ENG_IDLE;
						end else
							sdo <= shReg[7]; // falling edge, next bit out
					end
				spiFlashPkg::ENG_HOLD:
					if (halfTick) begin
						csx <= 1'b1; // transaction over
						state <= spiFlashPkg::ENG_IDLE;
					end
				default: state <= spiFlashPkg::ENG_IDLE;
			endcase
		end
	end

	// shift register and received byte
	always_ff @(posedge clk) begin
		if (start) begin
			shReg <= bufMem[rdPtr].data;
			curIsData <= bufMem[rdPtr].isData;
			curLast <= bufMem[rdPtr].last;
		end else if (state == spiFlashPkg::ENG_SHIFT && halfTick && !sck)
			shReg <= {shReg[6:0], sdi}; // sample sdi on rising sck
		if (byteDone)
			rx <= '{data: shReg, isData: curIsData, last: curLast};
	end

endmodule

//--- flashReadCollector.sv
// read collector of the flash read pipeline
// input stage that drops header bytes, read FIFO,
// consumer credit counter and credit return toward the engine
`timescale 1ns/1ps
`include "spiFlash_consts.svh"

module flashReadCollector (
	input  logic clk,
	input  logic rst,
	input  logic rxValid,
	input  spiFlashPkg::spiByte rx,
	output logic rxCredit,
	output logic rdValid,
	output spiFlashPkg::rdByte rd,
	input  logic rdCredit
);
	localparam int ptrW = (`RD_FIFO_DEPTH > 1) ? $clog2(`RD_FIFO_DEPTH) : 1;
	localparam int cntW = $clog2(`RD_FIFO_DEPTH + 1);
	localparam int crW = `MAX_LEN_W + 1; // consumer may grant a whole request ahead

	spiFlashPkg::spiByte stg; // byte one cycle after rxValid
	logic stgValid;
	spiFlashPkg::rdByte mem [`RD_FIFO_DEPTH];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic [crW-1:0] rdCnt;    // consumer credits on hand, none after reset
	logic wr;
	logic drop;
	logic pop;

	assign wr = stgValid && stg.isData;
	assign drop = stgValid && !stg.isData; // header byte, slot comes straight back
	assign pop = (count != '0) && (rdCnt != '0) && !drop; // one credit pulse per cycle
	assign rxCredit = drop | pop;

	always_ff @(posedge clk) begin
		if (rxValid)
			stg <= rx;
		if (wr)
			mem[wrPtr] <= '{data: stg.data, last: stg.last};
		if (pop)
			rd <= mem[rdPtr];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			stgValid <= 1'b0;
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			rdCnt <= '0;
			rdValid <= 1'b0;
		end else begin
			stgValid <= rxValid;
			if (wr)
				wrPtr <= (wrPtr == ptrW'(`RD_FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == ptrW'(`RD_FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + cntW'(wr) - cntW'(pop);
			rdCnt <= rdCnt + crW'(rdCredit) - crW'(pop);
			rdValid <= pop;
		end
	end

endmodule

//--- spiFlashTop.sv
// top level of the SPI flash read controller
// sequencer, byte engine and collector chained by credit links
`timescale 1ns/1ps

module spiFlashTop (
	input  logic clk,
	input  logic rst,
	input  logic reqValid,
	input  spiFlashPkg::flashReq req,
	output logic reqCredit,
	output logic rdValid,
	output spiFlashPkg::rdByte rd,
	input  logic rdCredit,
	output logic sck,
	output logic csx,
	output logic sdo,
	input  logic sdi
);
	logic txValid;            // sequencer to engine
	spiFlashPkg::spiByte tx;
	logic txCredit;
	logic rxValid;            // engine to collector
	spiFlashPkg::spiByte rx;
	logic rxCredit;

	flashCmdSequencer flashCmdSequencer_i (
		.clk(clk), .rst(rst),
		.reqValid(reqValid), .req(req), .reqCredit(reqCredit),
		.txValid(txValid), .tx(tx), .txCredit(txCredit)
	);

	spiByteEngine spiByteEngine_i (
		.clk(clk), .rst(rst),
		.txValid(txValid), .tx(tx), .txCredit(txCredit),
		.rxValid(rxValid), .rx(rx), .rxCredit(rxCredit),
		.sck(sck), .csx(csx), .sdo(sdo), .sdi(sdi)
	);

	flashReadCollector flashReadCollector_i (
		.clk(clk), .rst(rst),
		.rxValid(rxValid), .rx(rx), .rxCredit(rxCredit),
		.rdValid(rdValid), .rd(rd), .rdCredit(rdCredit)
	);

endmodule

//--- spiFlashModel.sv
// behavioral SPI NOR flash for the testbench, mode 0
// answers read data (03h) and JEDEC id (9Fh) on the SPI pins
// read byte at address a is a[7:0] ^ A5h, id bytes EFh 40h 15h repeating
`timescale 1ns/1ps

module spiFlashModel (
	input  logic sck,
	input  logic csx,
	input  logic sdo,
	output logic sdi
);
	logic [7:0] inSh;              // command bits from the controller
	logic [7:0] op;
	logic [23:0] addr;
	logic [7:0] outByte = 8'hFF;   // byte being answered
	logic outBit = 1'b0;
	int bitCnt = 0;                // bits of the current byte taken in
	int byteCnt = 0;               // whole bytes since csx fell
	logic [7:0] idBytes [3] = '{8'hEF, 8'h40, 8'h15};

	assign sdi = outBit;

	// command side, sdo sampled on rising sck
	always @(posedge sck or posedge csx) begin
		if (csx) begin
			bitCnt = 0; // deselect ends the command
			byteCnt = 0;
		end else begin
			inSh = {inSh[6:0], sdo};
			bitCnt++;
			if (bitCnt == 8) begin
				if (byteCnt == 0)
					op = inSh;
				else if (byteCnt <= 3)
					addr = {addr[15:0], inSh}; // msb byte first
				bitCnt = 0;
				byteCnt++;
			end
		end
	end

	// answer side, next bit goes out on falling sck
	always @(negedge sck) begin
		if (!csx) begin
			if (bitCnt == 0) begin
				if (op == 8'h9F)
					outByte = idBytes[(byteCnt - 1) % 3];
				else if (op == 8'h03 && byteCnt >= 4)
					outByte = (addr[7:0] + 8'(byteCnt - 4)) ^ 8'hA5; // address auto-increments
				else
					outByte = 8'hFF; // still in the header
			end
			outBit <= outByte[7 - bitCnt];
		end
	end

endmodule

//--- tbClock.sv
// testbench clock source
// 10 ns period, starts low
`timescale 1ns/1ps

module tbClock (
	output logic clk
);
	always begin
		clk = 1'b0;
		#5;
		clk = 1'b1; // rising edge every 10 ns
		#5;
	end

endmodule

//--- spiFlash_chk.sv
// protocol assertions for the SPI flash read controller
// reset state, sck idle while deselected, sdo stable while sck high,
// credit discipline on the request and read links
`timescale 1ns/1ps
`include "spiFlash_consts.svh"

module spiFlashChk (
	input logic clk,
	input logic rst,
	input logic reqValid,
	input logic reqCredit,
	input logic rdValid,
	input logic rdCredit,
	input logic sck,
	input logic csx,
	input logic sdo
);
	int reqAvail;       // sequencer slots the outside may still fill
	int rdAvail;        // consumer credits the collector has not used
	int failCount = 0;  // read by the testbench top

	always @(posedge clk) begin
		if (rst) begin
			reqAvail <= `REQ_DEPTH;
			rdAvail <= 0;
		end else begin
			reqAvail <= reqAvail + int'(reqCredit) - int'(reqValid);
			rdAvail <= rdAvail + int'(rdCredit) - int'(rdValid);
		end
	end

	resetState: assert property (@(posedge clk)
		rst |=> (csx && !sck && !sdo && !rdValid && !reqCredit))
		else begin
			$error("outputs not at their reset values");
			failCount++;
		end

	sckIdle: assert property (@(posedge clk) disable iff (rst) csx |-> !sck)
		else begin
			$error("sck active while csx is high");
			failCount++;
		end

	sdoStable: assert property (@(posedge clk) disable iff (rst)
		(sck && $past(sck)) |-> $stable(sdo)) // mode 0, data moves on falling sck only
		else begin
			$error("sdo changed while sck was high");
			failCount++;
		end

	reqOnCredit: assert property (@(posedge clk) disable iff (rst) reqValid |-> reqAvail > 0)
		else begin
			$error("request sent without a sequencer credit");
			failCount++;
		end

	rdOnCredit: assert property (@(posedge clk) disable iff (rst) rdValid |-> rdAvail > 0)
		else begin
			$error("read byte delivered without a consumer credit");
			failCount++;
		end

endmodule

//--- spiFlashTb.sv
// testbench top of the SPI flash read controller
// DUT with flash model, clock and bound protocol checker
// request driver with its own credit count, consumer credits with random gaps,
// read data checks against the flash contents
`timescale 1ns/1ps
`include "spiFlash_consts.svh"

module spiFlashTb;
	logic clk;
	logic rst = 1'b1;
	logic reqValid = 1'b0;
	spiFlashPkg::flashReq req = '0;
	logic reqCredit;
	logic rdValid;
	spiFlashPkg::rdByte rd;
	logic rdCredit = 1'b0;
	logic sck;
	logic csx;
	logic sdo;
	logic sdi;

	spiFlashPkg::rdByte expQ [$]; // bytes still owed in request order
	int reqSent = 0;
	int reqCreditsIn = 0;
	int expTotal = 0;
	int rcvCount = 0;
	int granted = 0;              // consumer credits handed out so far
	logic creditOn = 1'b1;
	logic [31:0] stimState = 32'd62035;
	logic [31:0] gapState = 32'd62035;

	tbClock clkGen_i (.clk(clk));

	spiFlashModel flash_i (.sck(sck), .csx(csx), .sdo(sdo), .sdi(sdi));

	spiFlashTop spiFlashTop_i (
		.clk(clk), .rst(rst),
		.reqValid(reqValid), .req(req), .reqCredit(reqCredit),
		.rdValid(rdValid), .rd(rd), .rdCredit(rdCredit),
		.sck(sck), .csx(csx), .sdo(sdo), .sdi(sdi)
	);

	bind spiFlashTop spiFlashChk spiFlashChk_i (
		.clk(clk), .rst(rst), .reqValid(reqValid), .reqCredit(reqCredit),
		.rdValid(rdValid), .rdCredit(rdCredit), .sck(sck), .csx(csx), .sdo(sdo)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic reportMismatch(input string sig, input logic [7:0] expV,
			input logic [7:0] actV);
		$display("ERROR at %0t ns: %s expected %02h got %02h", $time, sig, expV, actV);
		abortRun("read data differs from the flash contents");
	endtask

	// waits for a free sequencer slot and queues the bytes the request must return
	task automatic sendReq(input spiFlashPkg::flashOp op, input logic [23:0] addr,
			input int len);
		int waitCnt;
		spiFlashPkg::rdByte e;
		logic [7:0] idBytes [3];
		idBytes = '{8'hEF, 8'h40, 8'h15};
		waitCnt = 0;
		while (`REQ_DEPTH + reqCreditsIn - reqSent <= 0) begin
			waitCnt++;
			if (waitCnt > 5000)
				abortRun("sequencer returned no request credit in time");
			@(posedge clk);
		end
		req <= '{op: op, addr: addr, len: `MAX_LEN_W'(len)};
		reqValid <= 1'b1;
		reqSent++;
		for (int i = 0; i < len; i++) begin
			if (op == spiFlashPkg::OP_JEDEC)
				e.data = idBytes[i % 3]; // id repeats past three bytes
			else
				e.data = (addr[7:0] + 8'(i)) ^ 8'hA5;
			e.last = (i == len - 1);
			expQ.push_back(e);
		end
		expTotal += len;
		@(posedge clk);
		reqValid <= 1'b0; // a following sendReq in this cycle overrides it
	endtask

	task automatic waitAllRead(input int limit);
		int waitCnt;
		waitCnt = 0;
		while (rcvCount != expTotal) begin
			waitCnt++;
			if (waitCnt > limit)
				abortRun("read data did not all come back in time");
			@(posedge clk);
		end
	endtask

	always @(posedge clk) begin
		if (reqCredit)
			reqCreditsIn <= reqCreditsIn + 1;
	end

	// consumer grants credits with random gaps and at most 6 outstanding
	always @(posedge clk) begin : consumer
		gapState = xorshift32(gapState);
		if (!rst && creditOn && granted - rcvCount < 6 && gapState[1:0] != 2'b00) begin
			rdCredit <= 1'b1;
			granted <= granted + 1;
		end else
			rdCredit <= 1'b0;
	end

	always @(posedge clk) begin : readCheck
		spiFlashPkg::rdByte e;
		if (!rst && rdValid) begin
			assert (expQ.size() != 0)
				else abortRun("a read byte came back that no request asked for");
			e = expQ.pop_front();
			assert (rd.data == e.data) else reportMismatch("rd.data", e.data, rd.data);
			assert (rd.last == e.last) else reportMismatch("rd.last", 8'(e.last), 8'(rd.last));
			rcvCount <= rcvCount + 1;
		end
	end

	always @(posedge clk) begin
		if (spiFlashTop_i.spiFlashChk_i.failCount != 0)
			abortRun("a protocol assertion in the checker failed");
	end

	initial begin : stimulus
		logic [23:0] addr;
		int len;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		sendReq(spiFlashPkg::OP_JEDEC, 24'h000000, 3);
		repeat (5) begin // random reads with several in flight
			stimState = xorshift32(stimState);
			addr = stimState[23:0];
			stimState = xorshift32(stimState);
			len = 1 + int'(stimState[3:0]);
			sendReq(spiFlashPkg::OP_READ, addr, len);
		end
		waitAllRead(20000);
		creditOn <= 1'b0; // fifo fills and the engine stalls between bytes
		sendReq(spiFlashPkg::OP_READ, 24'h1234FE, 12);
		repeat (1000) @(posedge clk); // long enough to drain leftover credits and stall
		creditOn <= 1'b1;
		waitAllRead(20000);
		sendReq(spiFlashPkg::OP_READ, 24'hABCDEF, 5); // three queued back to back
		sendReq(spiFlashPkg::OP_JEDEC, 24'h000000, 4);
		sendReq(spiFlashPkg::OP_READ, 24'h0000F0, 20);
		waitAllRead(20000);
		repeat (50) @(posedge clk); // room for stray bytes to show up
		if (spiFlashTop_i.spiFlashChk_i.failCount != 0)
			abortRun("a protocol assertion in the checker failed");
		else if (rcvCount == expTotal && expQ.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else
			abortRun("read byte count does not match the requests");
	end

endmodule

//--- spiFlash.f
+incdir+.
spiFlashPkg.sv
flashCmdSequencer.sv
spiByteEngine.sv
flashReadCollector.sv
spiFlashTop.sv
spiFlashModel.sv
tbClock.sv
spiFlash_chk.sv
spiFlashTb.sv
